//--- Bender.yml
package:
  name: dual_issue_front

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pipe_pkg.sv
      - source/fetch_counter.sv
      - source/if_id_stage.sv
      - source/hazard_detection_unit.sv
      - source/id_ex_stage.sv
      - source/dual_issue_front.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_dual_issue_front.sv

//--- bench/tb_dual_issue_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module tb_dual_issue_front;

  import pipe_pkg::*;

  localparam int NUM_ENTRIES = 12;
  localparam int RESET_CYCLES = 4;
  localparam time CLK_PERIOD = 100;
  localparam time DRIVE_DELAY = 10;

  typedef enum logic [1:0] {
    cls_none,
    cls_load_use,
    cls_intra
  } hazard_class_e;

  typedef struct packed {
    issue_slot_t s0;
    issue_slot_t s1;
    logic first;
    hazard_class_e cls;
  } prog_entry_t;

  logic clk;
  logic arst_n;
  issue_slot_t [1:0] imem_pair;
  logic imem_first;
  pc_t pc;
  pipe_mask_t stall0;
  pipe_mask_t stall1;
  pipe_mask_t flush0;
  pipe_mask_t flush1;
  issue_slot_t ex_lane0;
  issue_slot_t ex_lane1;
  mem_op_e ex_mem_op;
  reg_idx_t ex_rt;

  prog_entry_t prog [NUM_ENTRIES];
  issue_slot_t order_exp[$];
  issue_slot_t order_got[$];
  int errors;
  int checks;

  // reference model of the front.
  pc_t m_pc;
  int m_idx; // -1 when IF/ID holds a nop pair.
  logic m_phase; // younger slot still waiting.
  logic m_bubbled;
  issue_slot_t m_lane0;
  issue_slot_t m_lane1;
  int m_issued;

  dual_issue_front u_dual_issue_front (
    .clk(clk),
    .arst_n(arst_n),
    .imem_pair(imem_pair),
    .imem_first(imem_first),
    .pc(pc),
    .stall0(stall0),
    .stall1(stall1),
    .flush0(flush0),
    .flush1(flush1),
    .ex_lane0(ex_lane0),
    .ex_lane1(ex_lane1),
    .ex_mem_op(ex_mem_op),
    .ex_rt(ex_rt)
  );

  function automatic issue_slot_t instr(input opcode_t op, input reg_idx_t rs,
                                        input reg_idx_t rt, input reg_idx_t rd);
    issue_slot_t s;
    s.opcode = op;
    s.rs = rs;
    s.rt = rt;
    s.rd = rd;
    return s;
  endfunction

  function automatic int fetch_index(input pc_t addr);
    int idx;
    idx = int'(addr >> 1);
    return (idx < NUM_ENTRIES) ? idx : -1;
  endfunction

  task automatic load_program();
    prog[0] = '{instr(`OP_CODE_ADD, 1, 2, 3), instr(`OP_CODE_SUB, 4, 5, 6), 1'b0, cls_none};
    prog[1] = '{instr(`OP_CODE_ADDI, 7, 8, 0), instr(`OP_CODE_AND, 9, 10, 11), 1'b1, cls_none};
    prog[2] = '{instr(`OP_CODE_LW, 12, 13, 0), instr(`OP_CODE_OR, 14, 15, 16), 1'b0, cls_none};
    prog[3] = '{instr(`OP_CODE_ADD, 13, 17, 18), instr(`OP_CODE_SUB, 19, 20, 21), 1'b0,
                cls_load_use}; // rs reads the loaded rt.
    prog[4] = '{instr(`OP_CODE_ADD, 1, 2, 22), instr(`OP_CODE_SW, 22, 23, 0), 1'b0, cls_intra};
    prog[5] = '{instr(`OP_CODE_SA, 0, 24, 0), instr(`OP_CODE_LA, 0, 24, 0), 1'b1, cls_intra};
    prog[6] = '{instr(`OP_CODE_JR, 25, 0, 0), instr(`OP_CODE_ADDI, 26, 25, 0), 1'b1, cls_intra};
    prog[7] = '{instr(`OP_CODE_LA, 0, 27, 0), instr(`OP_CODE_SW, 28, 27, 0), 1'b0, cls_intra};
    prog[8] = '{instr(`OP_CODE_JMP, 30, 30, 0), instr(`OP_CODE_ADDI, 29, 30, 0), 1'b1, cls_none};
    prog[9] = '{instr(`OP_CODE_SUB, 1, 2, 31), instr(`OP_CODE_LW, 3, 28, 0), 1'b1, cls_none};
    prog[10] = '{instr(`OP_CODE_ADD, 4, 5, 6), instr(`OP_CODE_SW, 7, 28, 0), 1'b0,
                 cls_load_use}; // load sits in lane 1.
    prog[11] = '{instr(`OP_CODE_JE, 0, 0, 8), instr(`OP_CODE_ADD, 8, 9, 10), 1'b0, cls_none};
  endtask

  // a split pair with slot 1 older issues slot 1 first.
  task automatic build_order();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (prog[i].cls == cls_intra && prog[i].first) begin
        order_exp.push_back(prog[i].s1);
        order_exp.push_back(prog[i].s0);
      end else begin
        order_exp.push_back(prog[i].s0);
        order_exp.push_back(prog[i].s1);
      end
    end
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input pipe_mask_t got, input pipe_mask_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_slot(input issue_slot_t got, input issue_slot_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mem_op(input mem_op_e got, input mem_op_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic hazard_class_e hazard_now();
    if (m_idx < 0) return cls_none;
    if (prog[m_idx].cls == cls_load_use && !m_bubbled) return cls_load_use;
    if (prog[m_idx].cls == cls_intra && !m_phase) return cls_intra;
    return cls_none;
  endfunction

  // what the model's IF/ID holds right now.
  task automatic current_ifid(output issue_slot_t s0, output issue_slot_t s1);
    s0 = '0;
    s1 = '0;
    if (m_idx >= 0) begin
      s0 = prog[m_idx].s0;
      s1 = prog[m_idx].s1;
      if (m_phase && prog[m_idx].first) s1 = '0; // older already gone.
      if (m_phase && !prog[m_idx].first) s0 = '0;
    end
  endtask

  task automatic compare_cycle();
    pipe_mask_t exp_stall [2];
    pipe_mask_t exp_flush [2];
    hazard_class_e cls;
    mem_op_e exp_op;
    reg_idx_t exp_rt;
    int young;
    cls = hazard_now();
    exp_stall = '{default: '0};
    exp_flush = '{default: '0};
    if (cls == cls_load_use) begin
      exp_stall = '{default: `PIPE_REG_PC | `PIPE_REG_IF_ID};
      exp_flush = '{default: `PIPE_REG_ID_EX};
    end else if (cls == cls_intra) begin
      young = prog[m_idx].first ? 0 : 1;
      exp_stall[young] = `PIPE_REG_PC | `PIPE_REG_IF_ID;
      exp_flush[young] = `PIPE_REG_ID_EX;
      exp_stall[1 - young] = `PIPE_REG_PC;
      exp_flush[1 - young] = `PIPE_REG_IF_ID;
    end
    check_pc(pc, m_pc, "pc");
    check_mask(stall0, exp_stall[0], "stall0");
    check_mask(stall1, exp_stall[1], "stall1");
    check_mask(flush0, exp_flush[0], "flush0");
    check_mask(flush1, exp_flush[1], "flush1");
    check_slot(ex_lane0, m_lane0, "ex_lane0");
    check_slot(ex_lane1, m_lane1, "ex_lane1");
    exp_op = mem_op_none;
    exp_rt = '0;
    if (m_lane0.opcode == `OP_CODE_LW) begin
      exp_op = mem_op_read;
      exp_rt = m_lane0.rt;
    end else if (m_lane1.opcode == `OP_CODE_LW) begin
      exp_op = mem_op_read;
      exp_rt = m_lane1.rt;
    end else if (m_lane0.opcode == `OP_CODE_SW || m_lane1.opcode == `OP_CODE_SW) begin
      exp_op = mem_op_write;
    end
    check_mem_op(ex_mem_op, exp_op, "ex_mem_op");
    if (exp_op == mem_op_read) check_reg(ex_rt, exp_rt, "ex_rt");
    if (m_lane0.opcode != `OP_CODE_NOP) m_issued++;
    if (m_lane1.opcode != `OP_CODE_NOP) m_issued++;
  endtask

  task automatic collect_lanes();
    if (ex_lane0.opcode != `OP_CODE_NOP) order_got.push_back(ex_lane0);
    if (ex_lane1.opcode != `OP_CODE_NOP) order_got.push_back(ex_lane1);
  endtask

  task automatic advance_model();
    issue_slot_t s0;
    issue_slot_t s1;
    current_ifid(s0, s1);
    case (hazard_now())
      cls_load_use: begin
        m_lane0 = '0;
        m_lane1 = '0;
        m_bubbled = 1'b1;
      end
      cls_intra: begin
        m_lane0 = prog[m_idx].first ? issue_slot_t'('0) : s0;
        m_lane1 = prog[m_idx].first ? s1 : issue_slot_t'('0);
        m_phase = 1'b1;
      end
      default: begin
        m_lane0 = s0;
        m_lane1 = s1;
        m_idx = fetch_index(m_pc);
        m_pc = m_pc + pc_t'(2);
        m_phase = 1'b0;
        m_bubbled = 1'b0;
      end
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // imem answers the pc a little after each edge.
  always @(posedge clk) begin
    int idx;
    #(DRIVE_DELAY);
    idx = fetch_index(pc);
    imem_pair = (idx >= 0) ? {prog[idx].s1, prog[idx].s0} : '0;
    imem_first = (idx >= 0) ? prog[idx].first : 1'b0;
  end

  initial begin
    #((NUM_ENTRIES * 20 + RESET_CYCLES) * CLK_PERIOD);
    $display("Simulation timed out before the program drained through the pipeline");
    $display("Test failed");
    $finish;
  end

  initial begin
    errors = 0;
    checks = 0;
    arst_n = 1'b0;
    imem_pair = '0;
    imem_first = 1'b0;
    load_program();
    build_order();
    m_pc = '0;
    m_idx = -1;
    m_phase = 1'b0;
    m_bubbled = 1'b0;
    m_lane0 = '0;
    m_lane1 = '0;
    m_issued = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;
    while (m_issued < order_exp.size()) begin
      @(negedge clk); // outputs settled mid cycle.
      compare_cycle();
      collect_lanes();
      advance_model();
    end
    if (order_got.size() != order_exp.size()) begin
      errors++;
      $display("Error at %0t ns: %0d instructions issued, expected %0d", $time,
               order_got.size(), order_exp.size());
    end
    for (int i = 0; i < order_exp.size() && i < order_got.size(); i++) begin
      check_slot(order_got[i], order_exp[i], $sformatf("issue order entry %0d", i));
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/pipe_pkg.sv
source/fetch_counter.sv
source/if_id_stage.sv
source/hazard_detection_unit.sv
source/id_ex_stage.sv
source/dual_issue_front.sv
bench/tb_dual_issue_front.sv

//--- source/dual_issue_front.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_front (
  input logic clk,
  input logic arst_n,
  input pipe_pkg::issue_slot_t [1:0] imem_pair,
  input logic imem_first,
  output pipe_pkg::pc_t pc,
  output pipe_pkg::pipe_mask_t stall0,
  output pipe_pkg::pipe_mask_t stall1,
  output pipe_pkg::pipe_mask_t flush0,
  output pipe_pkg::pipe_mask_t flush1,
  output pipe_pkg::issue_slot_t ex_lane0,
  output pipe_pkg::issue_slot_t ex_lane1,
  output pipe_pkg::mem_op_e ex_mem_op,
  output pipe_pkg::reg_idx_t ex_rt
);

  import pipe_pkg::*;

  issue_slot_t id_slot0;
  issue_slot_t id_slot1;
  logic id_first;

  fetch_counter u_fetch_counter (
    .clk(clk),
    .arst_n(arst_n),
    .stall0(stall0),
    .stall1(stall1),
    .pc(pc)
  );

  if_id_stage u_if_id_stage (
    .clk(clk),
    .arst_n(arst_n),
    .fetch_pair(imem_pair),
    .fetch_first(imem_first),
    .stall0(stall0),
    .stall1(stall1),
    .flush0(flush0),
    .flush1(flush1),
    .slot0(id_slot0),
    .slot1(id_slot1),
    .first(id_first)
  );

  hazard_detection_unit u_hazard_detection_unit (
    .id_ex_mem_op(ex_mem_op),
    .id_ex_rt(ex_rt),
    .first(id_first),
    .slot0(id_slot0),
    .slot1(id_slot1),
    .stall0(stall0),
    .stall1(stall1),
    .flush0(flush0),
    .flush1(flush1)
  );

  id_ex_stage u_id_ex_stage (
    .clk(clk),
    .arst_n(arst_n),
    .slot0(id_slot0),
    .slot1(id_slot1),
    .flush0(flush0),
    .flush1(flush1),
    .lane0(ex_lane0),
    .lane1(ex_lane1),
    .id_ex_mem_op(ex_mem_op),
    .id_ex_rt(ex_rt)
  );

endmodule

`default_nettype wire

//--- source/fetch_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module fetch_counter (
  input logic clk,
  input logic arst_n,
  input pipe_pkg::pipe_mask_t stall0,
  input pipe_pkg::pipe_mask_t stall1,
  output pipe_pkg::pc_t pc
);

  import pipe_pkg::*;

  logic hold;

  // either slot may freeze the fetch.
  assign hold = |((stall0 | stall1) & `PIPE_REG_PC);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (!hold) begin
      pc <= pc + pc_t'(2); // one pair per cycle.
    end
  end

endmodule

`default_nettype wire

//--- source/hazard_detection_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module hazard_detection_unit (
  input pipe_pkg::mem_op_e id_ex_mem_op,
  input pipe_pkg::reg_idx_t id_ex_rt,
  input logic first,
  input pipe_pkg::issue_slot_t slot0,
  input pipe_pkg::issue_slot_t slot1,
  output pipe_pkg::pipe_mask_t stall0,
  output pipe_pkg::pipe_mask_t stall1,
  output pipe_pkg::pipe_mask_t flush0,
  output pipe_pkg::pipe_mask_t flush1
);

  import pipe_pkg::*;

  logic load_use;
  logic slot0_reads_load;
  logic slot1_reads_load;

  issue_slot_t young;
  issue_slot_t old;
  reg_mask_t young_src;
  reg_mask_t old_dst;
  reg_idx_t old_dst_reg;
  logic old_writes;
  logic young_rs_hit;
  logic young_rt_hit;
  logic pair_hit;

  // raw rs and rt compare without decode.
  assign slot0_reads_load = (slot0.rs == id_ex_rt) || (slot0.rt == id_ex_rt);
  assign slot1_reads_load = (slot1.rs == id_ex_rt) || (slot1.rt == id_ex_rt);
  assign load_use = (id_ex_mem_op == mem_op_read) && (slot0_reads_load || slot1_reads_load);

  // first high means slot 1 is the older one.
  assign young = first ? slot0 : slot1;
  assign old = first ? slot1 : slot0;

  assign young_src = src_mask_of(young.opcode);
  assign old_dst = dst_mask_of(old.opcode);

  // at most one destination field per opcode.
  assign old_writes = |old_dst;
  assign old_dst_reg = |(old_dst & `REG_MASK_RD) ? old.rd : old.rt;

  assign young_rs_hit = |(young_src & `REG_MASK_RS) && (young.rs == old_dst_reg);
  assign young_rt_hit = |(young_src & `REG_MASK_RT) && (young.rt == old_dst_reg);
  assign pair_hit = old_writes && (young_rs_hit || young_rt_hit);

  always_comb begin
    stall0 = '0;
    stall1 = '0;
    flush0 = '0;
    flush1 = '0;

    if (load_use) begin
      // one bubble in both lanes.
      stall0 = `PIPE_REG_PC | `PIPE_REG_IF_ID;
      flush0 = `PIPE_REG_ID_EX;
      stall1 = `PIPE_REG_PC | `PIPE_REG_IF_ID;
      flush1 = `PIPE_REG_ID_EX;
    end else if (pair_hit) begin
      if (first) begin
        stall0 = `PIPE_REG_PC | `PIPE_REG_IF_ID; // younger waits.
        flush0 = `PIPE_REG_ID_EX;
        stall1 = `PIPE_REG_PC;
        flush1 = `PIPE_REG_IF_ID; // older issues now.
      end else begin
        stall1 = `PIPE_REG_PC | `PIPE_REG_IF_ID;
        flush1 = `PIPE_REG_ID_EX;
        stall0 = `PIPE_REG_PC;
        flush0 = `PIPE_REG_IF_ID;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/id_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module id_ex_stage (
  input logic clk,
  input logic arst_n,
  input pipe_pkg::issue_slot_t slot0,
  input pipe_pkg::issue_slot_t slot1,
  input pipe_pkg::pipe_mask_t flush0,
  input pipe_pkg::pipe_mask_t flush1,
  output pipe_pkg::issue_slot_t lane0,
  output pipe_pkg::issue_slot_t lane1,
  output pipe_pkg::mem_op_e id_ex_mem_op,
  output pipe_pkg::reg_idx_t id_ex_rt
);

  import pipe_pkg::*;

  issue_slot_t [1:0] lanes_q;
  issue_slot_t [1:0] lanes_d;
  logic [1:0] bubble;
  mem_op_e op0;
  mem_op_e op1;

  assign bubble = {|(flush1 & `PIPE_REG_ID_EX), |(flush0 & `PIPE_REG_ID_EX)};
  assign lanes_d = {slot1, slot0};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lanes_q <= {NOP_SLOT, NOP_SLOT};
    end else begin
      for (int n = 0; n < 2; n++) begin
        lanes_q[n] <= bubble[n] ? NOP_SLOT : lanes_d[n];
      end
    end
  end

  assign lane0 = lanes_q[0];
  assign lane1 = lanes_q[1];

  assign op0 = mem_op_of(lanes_q[0].opcode);
  assign op1 = mem_op_of(lanes_q[1].opcode);

  // a load in either lane takes priority over a store.
  always_comb begin
    if (op0 == mem_op_read) begin
      id_ex_mem_op = op0;
      id_ex_rt = lanes_q[0].rt;
    end else if (op1 == mem_op_read) begin
      id_ex_mem_op = op1;
      id_ex_rt = lanes_q[1].rt;
    end else if (op0 != mem_op_none) begin
      id_ex_mem_op = op0;
      id_ex_rt = lanes_q[0].rt;
    end else begin
      id_ex_mem_op = op1;
      id_ex_rt = lanes_q[1].rt;
    end
  end

endmodule

`default_nettype wire

//--- source/if_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module if_id_stage (
  input logic clk,
  input logic arst_n,
  input pipe_pkg::issue_slot_t [1:0] fetch_pair,
  input logic fetch_first,
  input pipe_pkg::pipe_mask_t stall0,
  input pipe_pkg::pipe_mask_t stall1,
  input pipe_pkg::pipe_mask_t flush0,
  input pipe_pkg::pipe_mask_t flush1,
  output pipe_pkg::issue_slot_t slot0,
  output pipe_pkg::issue_slot_t slot1,
  output logic first
);

  import pipe_pkg::*;

  issue_slot_t [1:0] slots_q;
  logic [1:0] hold;
  logic [1:0] clear;

  assign hold = {|(stall1 & `PIPE_REG_IF_ID), |(stall0 & `PIPE_REG_IF_ID)};
  assign clear = {|(flush1 & `PIPE_REG_IF_ID), |(flush0 & `PIPE_REG_IF_ID)};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slots_q <= {NOP_SLOT, NOP_SLOT};
      first <= 1'b0;
    end else begin
      // a split pair drains one slot while the other waits.
      for (int n = 0; n < 2; n++) begin
        if (!hold[n]) begin
          slots_q[n] <= clear[n] ? NOP_SLOT : fetch_pair[n];
        end
      end
      // the flag travels with slot 0.
      if (!hold[0]) begin
        first <= clear[0] ? 1'b0 : fetch_first;
      end
    end
  end

  assign slot0 = slots_q[0];
  assign slot1 = slots_q[1];

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

`include "pipe_settings.svh"

package pipe_pkg;

  typedef logic [`OP_CODE_BITS-1:0] opcode_t;
  typedef logic [`NUM_REGISTERS_LOG2-1:0] reg_idx_t;
  typedef logic [`PC_BITS-1:0] pc_t;
  typedef logic [`NUM_PIPE_MASKS-1:0] pipe_mask_t;
  typedef logic [`NUM_REG_MASKS-1:0] reg_mask_t;

  typedef enum logic [1:0] {
    mem_op_none,
    mem_op_read,
    mem_op_write
  } mem_op_e;

  typedef struct packed {
    opcode_t opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
  } issue_slot_t;

  localparam issue_slot_t NOP_SLOT = '0; // all-zero opcode and fields.

  // registers read by an opcode. first matching item wins.
  function automatic reg_mask_t src_mask_of(input opcode_t op);
    case (op) inside
      `OP_CODE_NOP: return '0;
      `OP_CODE_JR: return `REG_MASK_RS;
      6'b00????: return `REG_MASK_RS | `REG_MASK_RT;
      6'b01????: return `REG_MASK_RS;
      `OP_CODE_LW: return `REG_MASK_RS;
      `OP_CODE_SW: return `REG_MASK_RS | `REG_MASK_RT;
      `OP_CODE_SA: return `REG_MASK_RT; // address is absolute.
      default: return '0; // jumps, la, unused.
    endcase
  endfunction

  // registers written by an opcode.
  function automatic reg_mask_t dst_mask_of(input opcode_t op);
    case (op) inside
      `OP_CODE_NOP: return '0;
      `OP_CODE_JR: return '0;
      6'b00????: return `REG_MASK_RD;
      6'b01????: return `REG_MASK_RT;
      `OP_CODE_LW: return `REG_MASK_RT;
      `OP_CODE_LA: return `REG_MASK_RT;
      default: return '0;
    endcase
  endfunction

  function automatic mem_op_e mem_op_of(input opcode_t op);
    case (op)
      `OP_CODE_LW: return mem_op_read;
      `OP_CODE_SW: return mem_op_write;
      default: return mem_op_none;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- source/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

`define OP_CODE_BITS 6
`define NUM_REGISTERS_LOG2 5
`define NUM_PIPE_MASKS 3
`define NUM_REG_MASKS 3
`define PC_BITS 16

// register ops in the 00 group.
`define OP_CODE_NOP 6'b000000
`define OP_CODE_ADD 6'b000001
`define OP_CODE_SUB 6'b000010
`define OP_CODE_AND 6'b000011
`define OP_CODE_OR 6'b000100
`define OP_CODE_JR 6'b001000

// immediate ops in the 01 group.
`define OP_CODE_ADDI 6'b010000
`define OP_CODE_SUBI 6'b010001

// memory ops in the 10 group.
`define OP_CODE_LW 6'b100000
`define OP_CODE_SW 6'b100001
`define OP_CODE_LA 6'b100010
`define OP_CODE_SA 6'b100011

// jumps in the 11 group.
`define OP_CODE_JMP 6'b110000
`define OP_CODE_JO 6'b110001
`define OP_CODE_JE 6'b110010

`define PIPE_REG_PC 3'b001
`define PIPE_REG_IF_ID 3'b010
`define PIPE_REG_ID_EX 3'b100

`define REG_MASK_RS 3'b001
`define REG_MASK_RT 3'b010
`define REG_MASK_RD 3'b100

`endif
